//--- Bender.yml
package:
  name: history_top

sources:
  - bp_cfg_pkg.sv
  - bp_hist_pkg.sv
  - fold_compress.sv
  - fold_history_unit.sv
  - ghist_buffer.sv
  - history_ctrl.sv
  - history_top.sv
  - target: test
    files:
      - history_checker.sv
      - tb_history_top.sv

//--- bp_cfg_pkg.sv
package bp_cfg_pkg;

    // Global history buffer, one bit per conditional branch
    localparam int GHIST_SIZE = 64;
    localparam int GHIST_IDX_W = $clog2(GHIST_SIZE);

    // Conditional branches reported per fetch block
    localparam int SLOT_NUM = 2;

    // Tagged banks and the history length each one sees
    localparam int TAGE_BANK = 4;
    localparam int TAGE_HIST_LEN [TAGE_BANK] = '{8, 13, 21, 32};

    // Folded history widths, shared by all banks
    localparam int IDX_FOLD_W = 8;
    localparam int TAG1_FOLD_W = 9; // Coprime with the index fold width
    localparam int TAG2_FOLD_W = 8;

endpackage

//--- bp_hist_pkg.sv
package bp_hist_pkg;

    // Compressed history of one bank, index fold in the upper bits
    typedef struct packed {
        logic [bp_cfg_pkg::IDX_FOLD_W-1:0]  idx_fold;
        logic [bp_cfg_pkg::TAG1_FOLD_W-1:0] tag1_fold;
        logic [bp_cfg_pkg::TAG2_FOLD_W-1:0] tag2_fold;
    } bank_fold_t;

    // All banks, bank 0 in the lowest bits
    typedef bank_fold_t [bp_cfg_pkg::TAGE_BANK-1:0] fold_hist_t;

endpackage

//--- fold_compress.sv
`timescale 1ns/1ps

module fold_compress #(
    parameter int COMPRESS_LENGTH = 8,
    parameter int ORIGIN_LENGTH = 10
) (
    input  logic [COMPRESS_LENGTH-1:0]      origin,
    input  logic [1:0]                      cond_num,
    input  logic                            dir,
    input  logic [bp_cfg_pkg::SLOT_NUM-1:0] reverse_dir,
    output logic [COMPRESS_LENGTH-1:0]      fold
);
    // Fold positions of the bits that leave the window
    localparam int OUT_POS0 = ORIGIN_LENGTH % COMPRESS_LENGTH;
    localparam int OUT_POS1 = (ORIGIN_LENGTH + 1) % COMPRESS_LENGTH;

    logic [COMPRESS_LENGTH-1:0] rot1;
    logic [COMPRESS_LENGTH-1:0] rot2;

    assign rot1 = {origin[COMPRESS_LENGTH-2:0], origin[COMPRESS_LENGTH-1]};
    assign rot2 = {origin[COMPRESS_LENGTH-3:0], origin[COMPRESS_LENGTH-1 -: 2]};

    always_comb begin
        fold = origin; // No new outcome, fold passes through
        case (cond_num)
            2'd1: begin
                fold = rot1;
                fold[0] = rot1[0] ^ dir;
                fold[OUT_POS0] = fold[OUT_POS0] ^ reverse_dir[0];
            end
            2'd2: begin
                // First slot is a not-taken branch, it adds nothing at bit 1
                fold = rot2;
                fold[0] = rot2[0] ^ dir;
                fold[OUT_POS1] = fold[OUT_POS1] ^ reverse_dir[0]; // Oldest bit is two older now
                fold[OUT_POS0] = fold[OUT_POS0] ^ reverse_dir[1];
            end
            default: ;
        endcase
    end

endmodule

//--- fold_history_unit.sv
`timescale 1ns/1ps

module fold_history_unit (
    input  logic                                                   clk,
    input  logic                                                   rst_n,
    input  bp_hist_pkg::fold_hist_t                                fold_base,
    input  logic [1:0]                                             upd_cond_num,
    input  logic                                                   upd_taken,
    input  logic [bp_cfg_pkg::TAGE_BANK-1:0][bp_cfg_pkg::SLOT_NUM-1:0] age_bits,
    input  logic                                                   fold_we,
    output bp_hist_pkg::fold_hist_t                                fold_cur
);
    import bp_cfg_pkg::*;
    import bp_hist_pkg::*;

    wire fold_hist_t fold_nxt; // Driven field by field from the compressors

    for (genvar b = 0; b < TAGE_BANK; b++) begin : g_bank
        fold_compress #(
            .COMPRESS_LENGTH(IDX_FOLD_W),
            .ORIGIN_LENGTH  (TAGE_HIST_LEN[b])
        ) idx_compress_i (
            .origin     (fold_base[b].idx_fold),
            .cond_num   (upd_cond_num),
            .dir        (upd_taken),
            .reverse_dir(age_bits[b]),
            .fold       (fold_nxt[b].idx_fold)
        );

        fold_compress #(
            .COMPRESS_LENGTH(TAG1_FOLD_W),
            .ORIGIN_LENGTH  (TAGE_HIST_LEN[b])
        ) tag1_compress_i (
            .origin     (fold_base[b].tag1_fold),
            .cond_num   (upd_cond_num),
            .dir        (upd_taken),
            .reverse_dir(age_bits[b]),
            .fold       (fold_nxt[b].tag1_fold)
        );

        fold_compress #(
            .COMPRESS_LENGTH(TAG2_FOLD_W),
            .ORIGIN_LENGTH  (TAGE_HIST_LEN[b])
        ) tag2_compress_i (
            .origin     (fold_base[b].tag2_fold),
            .cond_num   (upd_cond_num),
            .dir        (upd_taken),
            .reverse_dir(age_bits[b]),
            .fold       (fold_nxt[b].tag2_fold)
        );
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fold_cur <= '0;
        end else if (fold_we) begin
            fold_cur <= fold_nxt;
        end
    end

endmodule

//--- ghist_buffer.sv
`timescale 1ns/1ps

module ghist_buffer (
    input  logic                                                       clk,
    input  logic                                                       rst_n,
    input  logic [bp_cfg_pkg::SLOT_NUM-1:0]                            wr_en,
    input  logic [bp_cfg_pkg::GHIST_IDX_W-1:0]                         wr_idx_base,
    input  logic [bp_cfg_pkg::SLOT_NUM-1:0]                            wr_bits,
    input  logic [bp_cfg_pkg::GHIST_IDX_W-1:0]                         next_pos,
    input  logic [bp_cfg_pkg::GHIST_IDX_W-1:0]                         rd_idx,
    output logic [bp_cfg_pkg::GHIST_IDX_W-1:0]                         pos,
    output logic [bp_cfg_pkg::TAGE_BANK-1:0][bp_cfg_pkg::SLOT_NUM-1:0] age_bits
);
    import bp_cfg_pkg::*;

    logic [GHIST_SIZE-1:0] ghist;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pos <= '0;
            ghist <= '0;
        end else begin
            pos <= next_pos;
            for (int i = 0; i < SLOT_NUM; i++) begin
                if (wr_en[i]) begin
                    ghist[wr_idx_base + GHIST_IDX_W'(i)] <= wr_bits[i]; // Wraps at buffer end
                end
            end
        end
    end

    // Slot 0 is the oldest bit of the bank window, slot 1 the next one up
    always_comb begin
        for (int b = 0; b < TAGE_BANK; b++) begin
            for (int s = 0; s < SLOT_NUM; s++) begin
                age_bits[b][s] = ghist[rd_idx - GHIST_IDX_W'(TAGE_HIST_LEN[b] - s)];
            end
        end
    end

endmodule

//--- history_checker.sv
`timescale 1ns/1ps

module history_checker (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic                               res_en,
    input  logic [1:0]                         res_cond_num,
    input  logic                               res_taken,
    input  logic                               s2_redirect,
    input  logic [bp_cfg_pkg::GHIST_IDX_W-1:0] res_redir_idx,
    input  logic                               squash,
    input  logic [1:0]                         sq_cond_num,
    input  logic                               sq_taken,
    input  logic                               flush,
    input  logic [bp_cfg_pkg::GHIST_IDX_W-1:0] sq_redir_idx,
    input  logic [bp_cfg_pkg::GHIST_IDX_W-1:0] ghist_idx,
    input  bp_hist_pkg::fold_hist_t            fold_hist,
    output logic                               ready,
    output int                                 checks,
    output int                                 errors
);
    import bp_cfg_pkg::*;

    logic [GHIST_SIZE-1:0]  ref_hist; // Model of the circular history
    logic [GHIST_IDX_W-1:0] ref_pos;
    logic [GHIST_IDX_W-1:0] exp_idx;
    logic [GHIST_IDX_W-1:0] base;
    logic [1:0]             cond;
    logic                   taken;

    // XOR of the last len bits in width-bit chunks, newest bit at bit 0
    function automatic logic [8:0] fold_ref(input int len, input int width);
        logic [8:0] res;
        res = '0;
        for (int k = 0; k < len; k++) begin
            res[k % width] ^= ref_hist[(int'(ref_pos) - 1 - k + GHIST_SIZE) % GHIST_SIZE];
        end
        return res;
    endfunction

    task automatic compare_field(input string name, input logic [8:0] exp_v,
                                 input logic [8:0] got_v);
        if (got_v !== exp_v) begin
            errors++;
            $display("ERR %0t %s expected %h got %h", $time, name, exp_v, got_v);
        end
    endtask

    initial begin
        ready = 1'b0;
        checks = 0;
        errors = 0;
    end

    always @(negedge clk) begin
        if (rst_n !== 1'b1) begin
            ref_hist = '0;
            ref_pos = '0;
        end else begin
            ready = 1'b1;
            checks++;
            exp_idx = flush       ? sq_redir_idx :
                      s2_redirect ? res_redir_idx + GHIST_IDX_W'(res_cond_num) : ref_pos;
            compare_field("ghist_idx", exp_idx, ghist_idx);
            for (int b = 0; b < TAGE_BANK; b++) begin
                compare_field($sformatf("fold_hist[%0d].idx_fold", b),
                              fold_ref(TAGE_HIST_LEN[b], IDX_FOLD_W), fold_hist[b].idx_fold);
                compare_field($sformatf("fold_hist[%0d].tag1_fold", b),
                              fold_ref(TAGE_HIST_LEN[b], TAG1_FOLD_W), fold_hist[b].tag1_fold);
                compare_field($sformatf("fold_hist[%0d].tag2_fold", b),
                              fold_ref(TAGE_HIST_LEN[b], TAG2_FOLD_W), fold_hist[b].tag2_fold);
            end
            // State after the coming rising edge
            cond = squash ? sq_cond_num : (res_en || s2_redirect) ? res_cond_num : 2'd0;
            taken = squash ? sq_taken : res_taken;
            base = flush ? sq_redir_idx : s2_redirect ? res_redir_idx : ref_pos;
            for (int i = 0; i < int'(cond); i++) begin
                ref_hist[(int'(base) + i) % GHIST_SIZE] = taken && (i == int'(cond) - 1);
            end
            ref_pos = base + GHIST_IDX_W'(cond);
        end
    end

endmodule

//--- history_ctrl.sv
`timescale 1ns/1ps

module history_ctrl (
    input  logic                                   res_en,
    input  logic [1:0]                             res_cond_num,
    input  logic                                   res_taken,
    input  logic                                   s2_redirect,
    input  logic [bp_cfg_pkg::GHIST_IDX_W-1:0]     res_redir_idx,
    input  bp_hist_pkg::fold_hist_t                res_redir_fold,
    input  logic                                   squash,
    input  logic [1:0]                             sq_cond_num,
    input  logic                                   sq_taken,
    input  logic                                   flush,
    input  logic [bp_cfg_pkg::GHIST_IDX_W-1:0]     sq_redir_idx,
    input  bp_hist_pkg::fold_hist_t                sq_redir_fold,
    input  logic [bp_cfg_pkg::GHIST_IDX_W-1:0]     pos,
    input  bp_hist_pkg::fold_hist_t                fold_cur,
    output logic [bp_cfg_pkg::SLOT_NUM-1:0]        wr_en,
    output logic [bp_cfg_pkg::GHIST_IDX_W-1:0]     wr_idx_base,
    output logic [bp_cfg_pkg::SLOT_NUM-1:0]        wr_bits,
    output logic [bp_cfg_pkg::GHIST_IDX_W-1:0]     next_pos,
    output bp_hist_pkg::fold_hist_t                fold_base,
    output logic [1:0]                             upd_cond_num,
    output logic                                   upd_taken,
    output logic                                   fold_we,
    output logic [bp_cfg_pkg::GHIST_IDX_W-1:0]     ghist_idx,
    output bp_hist_pkg::fold_hist_t                fold_hist
);
    import bp_cfg_pkg::*;

    logic restore;

    assign restore = flush | s2_redirect;

    // Squash outcome wins, redirect carries the corrected prediction result
    assign upd_cond_num = squash                 ? sq_cond_num  :
                          (res_en | s2_redirect) ? res_cond_num : 2'd0;
    assign upd_taken = squash ? sq_taken : res_taken;

    // Restore base, flush first
    assign wr_idx_base = flush       ? sq_redir_idx  :
                         s2_redirect ? res_redir_idx : pos;
    assign fold_base = flush       ? sq_redir_fold  :
                       s2_redirect ? res_redir_fold : fold_cur;

    // Earlier branches are not taken, direction goes in the last used slot
    always_comb begin
        for (int i = 0; i < SLOT_NUM; i++) begin
            wr_en[i] = upd_cond_num > 2'(i);
            wr_bits[i] = upd_taken & (upd_cond_num == 2'(i + 1));
        end
    end

    assign next_pos = wr_idx_base + GHIST_IDX_W'(upd_cond_num);
    assign fold_we = (|wr_en) | restore; // Restore loads the fold even without outcomes

    assign ghist_idx = flush       ? sq_redir_idx :
                       s2_redirect ? res_redir_idx + GHIST_IDX_W'(res_cond_num) : pos;
    assign fold_hist = fold_cur;

endmodule

//--- history_top.f
bp_cfg_pkg.sv
bp_hist_pkg.sv
fold_compress.sv
fold_history_unit.sv
ghist_buffer.sv
history_ctrl.sv
history_top.sv
history_checker.sv
tb_history_top.sv

//--- history_top.sv
`timescale 1ns/1ps

module history_top (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic                               res_en,
    input  logic [1:0]                         res_cond_num,
    input  logic                               res_taken,
    input  logic                               s2_redirect,
    input  logic [bp_cfg_pkg::GHIST_IDX_W-1:0] res_redir_idx,
    input  bp_hist_pkg::fold_hist_t            res_redir_fold,
    input  logic                               squash,
    input  logic [1:0]                         sq_cond_num,
    input  logic                               sq_taken,
    input  logic                               flush,
    input  logic [bp_cfg_pkg::GHIST_IDX_W-1:0] sq_redir_idx,
    input  bp_hist_pkg::fold_hist_t            sq_redir_fold,
    output logic [bp_cfg_pkg::GHIST_IDX_W-1:0] ghist_idx,
    output bp_hist_pkg::fold_hist_t            fold_hist
);
    import bp_cfg_pkg::*;
    import bp_hist_pkg::*;

    logic [SLOT_NUM-1:0]                 wr_en;
    logic [GHIST_IDX_W-1:0]              wr_idx_base;
    logic [SLOT_NUM-1:0]                 wr_bits;
    logic [GHIST_IDX_W-1:0]              next_pos;
    logic [GHIST_IDX_W-1:0]              pos;
    logic [TAGE_BANK-1:0][SLOT_NUM-1:0]  age_bits;
    fold_hist_t                          fold_base;
    fold_hist_t                          fold_cur;
    logic [1:0]                          upd_cond_num;
    logic                                upd_taken;
    logic                                fold_we;

    history_ctrl history_ctrl_i (
        .res_en        (res_en),
        .res_cond_num  (res_cond_num),
        .res_taken     (res_taken),
        .s2_redirect   (s2_redirect),
        .res_redir_idx (res_redir_idx),
        .res_redir_fold(res_redir_fold),
        .squash        (squash),
        .sq_cond_num   (sq_cond_num),
        .sq_taken      (sq_taken),
        .flush         (flush),
        .sq_redir_idx  (sq_redir_idx),
        .sq_redir_fold (sq_redir_fold),
        .pos           (pos),
        .fold_cur      (fold_cur),
        .wr_en         (wr_en),
        .wr_idx_base   (wr_idx_base),
        .wr_bits       (wr_bits),
        .next_pos      (next_pos),
        .fold_base     (fold_base),
        .upd_cond_num  (upd_cond_num),
        .upd_taken     (upd_taken),
        .fold_we       (fold_we),
        .ghist_idx     (ghist_idx),
        .fold_hist     (fold_hist)
    );

    ghist_buffer ghist_buffer_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .wr_en      (wr_en),
        .wr_idx_base(wr_idx_base),
        .wr_bits    (wr_bits),
        .next_pos   (next_pos),
        .rd_idx     (wr_idx_base), // Aging bits sit below the update base
        .pos        (pos),
        .age_bits   (age_bits)
    );

    fold_history_unit fold_history_unit_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .fold_base   (fold_base),
        .upd_cond_num(upd_cond_num),
        .upd_taken   (upd_taken),
        .age_bits    (age_bits),
        .fold_we     (fold_we),
        .fold_cur    (fold_cur)
    );

endmodule

//--- tb_history_top.sv
`timescale 1ns/1ps

module tb_history_top;
    import bp_cfg_pkg::*;
    import bp_hist_pkg::*;

    logic                   clk;
    logic                   rst_n;
    logic                   res_en;
    logic [1:0]             res_cond_num;
    logic                   res_taken;
    logic                   s2_redirect;
    logic [GHIST_IDX_W-1:0] res_redir_idx;
    fold_hist_t             res_redir_fold;
    logic                   squash;
    logic [1:0]             sq_cond_num;
    logic                   sq_taken;
    logic                   flush;
    logic [GHIST_IDX_W-1:0] sq_redir_idx;
    fold_hist_t             sq_redir_fold;
    logic [GHIST_IDX_W-1:0] ghist_idx;
    fold_hist_t             fold_hist;
    logic                   ready;
    int                     checks;
    int                     errors;
    logic [31:0]            lfsr;
    int                     checks_seen;
    int                     timeouts;
    logic [GHIST_IDX_W-1:0] snap_idx [$]; // Oldest snapshot first
    fold_hist_t             snap_fold [$];

    history_top history_top_i (.*);

    history_checker history_checker_i (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] val;
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? (lfsr >> 1) ^ 32'h80200003 : lfsr >> 1;
            val = {val[30:0], lfsr[0]};
        end
        return val;
    endfunction

    function automatic logic [1:0] rand_cond();
        logic [1:0] c;
        c = 2'(rand_bits(2));
        return (c == 2'd3) ? 2'd1 : c;
    endfunction

    // Kinds 0 idle, 1 normal, 2 redirect, 3 squash, 4 flush, 5 flush with redirect
    task automatic run_cycle(input int kind);
        int k;
        @(posedge clk);
        #5;
        if (kind > 5 || (snap_idx.size() == 0 && (kind == 2 || kind >= 4))) begin
            kind = 1;
        end
        res_en = kind == 1 || kind == 2 || kind == 5;
        s2_redirect = kind == 2 || kind == 5;
        squash = kind >= 3;
        flush = kind >= 4;
        res_cond_num = rand_cond();
        res_taken = 1'(rand_bits(1));
        sq_cond_num = rand_cond();
        sq_taken = 1'(rand_bits(1));
        res_redir_idx = GHIST_IDX_W'(rand_bits(GHIST_IDX_W)); // Ignored without a redirect
        sq_redir_idx = GHIST_IDX_W'(rand_bits(GHIST_IDX_W));
        if (s2_redirect || flush) begin
            k = int'(rand_bits(4)) % snap_idx.size();
            sq_redir_idx = snap_idx[k];
            sq_redir_fold = snap_fold[k];
            res_redir_fold = ~snap_fold[k]; // Loses to flush
            if (!flush) begin
                res_redir_idx = snap_idx[k];
                res_redir_fold = snap_fold[k];
            end
            while (snap_idx.size() > k + 1) begin
                void'(snap_idx.pop_back()); // Younger snapshots are off the path
                void'(snap_fold.pop_back());
            end
        end
        @(negedge clk);
        if (!s2_redirect && !flush) begin
            snap_idx.push_back(ghist_idx);
            snap_fold.push_back(fold_hist);
            // Drop snapshots whose window the buffer may overwrite
            while (snap_idx.size() > 12 || GHIST_IDX_W'(ghist_idx - snap_idx[0]) > 28) begin
                void'(snap_idx.pop_front());
                void'(snap_fold.pop_front());
            end
        end
    endtask

    initial begin
        lfsr = 32'h6862;
        timeouts = 0;
        rst_n = 1'b0;
        {res_en, res_cond_num, res_taken, s2_redirect, res_redir_idx} = '0;
        {squash, sq_cond_num, sq_taken, flush, sq_redir_idx} = '0;
        res_redir_fold = '0;
        sq_redir_fold = '0;
        repeat (10) @(posedge clk);
        #5;
        rst_n = 1'b1;
        for (int i = 0; i < 20 && !ready; i++) begin
            @(posedge clk);
        end
        if (!ready) begin
            $display("Timeout: reset release was not seen within 20 cycles");
            timeouts++;
        end else begin
            for (int i = 0; i < 60; i++) begin
                run_cycle(1); // Well past the longest bank window
            end
            for (int i = 0; i < 240; i++) begin
                run_cycle(int'(rand_bits(3)));
            end
            for (int i = 0; i < 4; i++) begin
                run_cycle(5);
                run_cycle(0);
            end
            @(posedge clk); // Comparison of the last driven cycle is done by now
            checks_seen = checks;
            for (int i = 0; i < 10 && checks == checks_seen; i++) begin
                @(posedge clk);
            end
            if (checks == checks_seen) begin
                $display("Timeout: the checker stopped comparing outputs");
                timeouts++;
            end
        end
        $display("Checks: %0d  errors: %0d  timeouts: %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule
